// File: cpuPkg.sv
`default_nettype none

package cpuPkg;

    typedef logic [31:0] wordT;    // data or address word
    typedef logic [4:0]  regAddrT; // register index
    typedef logic [2:0]  funct3T;
    typedef logic [6:0]  funct7T;

    // major opcodes of the kept RV32I subset
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011
    } opcodeE;

    typedef enum logic {
        stRun    = 1'b0,
        stHalted = 1'b1
    } cpuStateE;

    localparam wordT instBytes = 32'd4; // pc step
    localparam int   regCount  = 32;

    // funct3 encodings for alu ops
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Sll    = 3'b001;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Sltu   = 3'b011;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3Srl    = 3'b101; // also sra
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    // funct3 encodings for branches, jalr and word access
    localparam funct3T f3Beq    = 3'b000;
    localparam funct3T f3Bne    = 3'b001;
    localparam funct3T f3Blt    = 3'b100;
    localparam funct3T f3Bge    = 3'b101;
    localparam funct3T f3Bltu   = 3'b110;
    localparam funct3T f3Bgeu   = 3'b111;
    localparam funct3T f3Jalr   = 3'b000;
    localparam funct3T f3Word   = 3'b010;

    localparam funct7T f7Zero   = 7'b0000000;
    localparam funct7T f7Alt    = 7'b0100000; // sub and sra

endpackage

`default_nettype wire

// File: decodeIf.sv
`timescale 1ns/100ps
`default_nettype none

interface decodeIf;
    import cpuPkg::*;

    opcodeE  opcode;  // may carry a value outside the enum
    funct3T  funct3;
    funct7T  funct7;
    regAddrT rs1;
    regAddrT rs2;
    regAddrT rd;
    wordT    imm;     // sign-extended, format picked by opcode
    logic    illegal; // encoding not supported

    modport decoder (
        output opcode, funct3, funct7, rs1, rs2, rd, imm, illegal
    );

    modport consumer (
        input opcode, funct3, funct7, rs1, rs2, rd, imm, illegal
    );

endinterface

`default_nettype wire

// File: instDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module instDecoder (
    input wire cpuPkg::wordT instWord,
    decodeIf.decoder         dec
);
    import cpuPkg::*;

    opcodeE opc;
    funct3T f3;
    funct7T f7;
    wordT   immI;
    wordT   immS;
    wordT   immB;
    wordT   immU;
    wordT   immJ;
    logic   altOk; // funct7 is zero or the sub/sra pattern

    assign opc = opcodeE'(instWord[6:0]);
    assign f3  = instWord[14:12];
    assign f7  = instWord[31:25];

    assign dec.opcode = opc;
    assign dec.funct3 = f3;
    assign dec.funct7 = f7;
    assign dec.rd     = instWord[11:7];
    assign dec.rs1    = instWord[19:15];
    assign dec.rs2    = instWord[24:20];

    assign immI = {{20{instWord[31]}}, instWord[31:20]};
    assign immS = {{20{instWord[31]}}, instWord[31:25], instWord[11:7]};
    assign immB = {{19{instWord[31]}}, instWord[31], instWord[7], instWord[30:25],
                   instWord[11:8], 1'b0};
    assign immU = {instWord[31:12], 12'b0};
    assign immJ = {{11{instWord[31]}}, instWord[31], instWord[19:12], instWord[20],
                   instWord[30:21], 1'b0};

    assign altOk = (f7 == f7Zero) || (f7 == f7Alt);

    always_comb begin
        dec.imm     = immI; // i-type unless the opcode says otherwise
        dec.illegal = 1'b0;
        case (opc)
            opLui, opAuipc: dec.imm = immU;
            opJal:          dec.imm = immJ;
            opJalr:         dec.illegal = (f3 != f3Jalr);
            opBranch: begin
                dec.imm     = immB;
                dec.illegal = (f3 == 3'b010) || (f3 == 3'b011);
            end
            opLoad:         dec.illegal = (f3 != f3Word);
            opStore: begin
                dec.imm     = immS;
                dec.illegal = (f3 != f3Word);
            end
            opImm: begin
                if (f3 == f3Sll) begin
                    dec.illegal = (f7 != f7Zero); // upper shamt field
                end else if (f3 == f3Srl) begin
                    dec.illegal = !altOk;
                end
            end
            opReg: begin
                if ((f3 == f3AddSub) || (f3 == f3Srl)) begin
                    dec.illegal = !altOk;
                end else begin
                    dec.illegal = (f7 != f7Zero);
                end
            end
            default:        dec.illegal = 1'b1; // unknown opcode
        endcase
    end

endmodule

`default_nettype wire

// File: executeUnit.sv
`timescale 1ns/100ps
`default_nettype none

module executeUnit (
    decodeIf.consumer          dec,
    input  wire cpuPkg::wordT  pc,
    input  wire cpuPkg::wordT  rs1Data,
    input  wire cpuPkg::wordT  rs2Data,
    input  wire cpuPkg::wordT  dataRdData,
    output cpuPkg::wordT       rdData,
    output cpuPkg::wordT       dataAddr,
    output cpuPkg::wordT       dataWrData,
    output logic               misaligned
);
    import cpuPkg::*;

    wordT       opB;      // second alu operand
    logic [4:0] shamt;
    logic       isSub;
    logic       isArith;  // arithmetic right shift
    wordT       aluOut;
    wordT       effAddr;
    wordT       linkAddr;
    logic       memOp;

    assign opB     = (dec.opcode == opReg) ? rs2Data : dec.imm;
    assign shamt   = opB[4:0];
    assign isSub   = (dec.opcode == opReg) && dec.funct7[5]; // only reg form subtracts
    assign isArith = dec.funct7[5];

    always_comb begin
        case (dec.funct3)
            f3AddSub: aluOut = isSub ? (rs1Data - opB) : (rs1Data + opB);
            f3Sll:    aluOut = rs1Data << shamt;
            f3Slt:    aluOut = {31'b0, $signed(rs1Data) < $signed(opB)};
            f3Sltu:   aluOut = {31'b0, rs1Data < opB};
            f3Xor:    aluOut = rs1Data ^ opB;
            f3Srl: begin
                if (isArith) begin
                    aluOut = wordT'($signed(rs1Data) >>> shamt);
                end else begin
                    aluOut = rs1Data >> shamt;
                end
            end
            f3Or:     aluOut = rs1Data | opB;
            f3And:    aluOut = rs1Data & opB;
            default:  aluOut = '0;
        endcase
    end

    // imm already holds the s or i format
    assign effAddr  = rs1Data + dec.imm;
    assign linkAddr = pc + instBytes;
    assign memOp    = (dec.opcode == opLoad) || (dec.opcode == opStore);

    assign misaligned = memOp && (effAddr[1:0] != 2'b00);
    assign dataAddr   = effAddr;
    assign dataWrData = rs2Data;

    always_comb begin
        case (dec.opcode)
            opLui:         rdData = dec.imm;
            opAuipc:       rdData = pc + dec.imm;
            opJal, opJalr: rdData = linkAddr; // return address
            opLoad:        rdData = dataRdData;
            opImm, opReg:  rdData = aluOut;
            default:       rdData = '0; // no rd write for these
        endcase
    end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  wire                  clk,
    input  wire cpuPkg::regAddrT rs1,
    input  wire cpuPkg::regAddrT rs2,
    output cpuPkg::wordT         rs1Data,
    output cpuPkg::wordT         rs2Data,
    input  wire cpuPkg::regAddrT rd,
    input  wire cpuPkg::wordT    rdData,
    input  wire                  regWrEn
);
    import cpuPkg::*;

    wordT regs [regCount]; // entry 0 is never written

    always_ff @(posedge clk) begin
        if (regWrEn && (rd != '0)) begin
            regs[rd] <= rdData;
        end
    end

    // x0 reads as zero regardless of array contents
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: programCounter.sv
`timescale 1ns/100ps
`default_nettype none

module programCounter #(
    parameter cpuPkg::wordT resetAddr = '0
) (
    input  wire               clk,
    input  wire               rst,
    decodeIf.consumer         dec,
    input  wire cpuPkg::wordT rs1Data,
    input  wire cpuPkg::wordT rs2Data,
    input  wire               pcEn,
    output cpuPkg::wordT      pc
);
    import cpuPkg::*;

    logic taken;    // branch condition holds
    wordT seqPc;
    wordT relPc;    // pc-relative target
    wordT jalrPc;
    wordT nextPc;

    always_comb begin
        case (dec.funct3)
            f3Beq:   taken = (rs1Data == rs2Data);
            f3Bne:   taken = (rs1Data != rs2Data);
            f3Blt:   taken = ($signed(rs1Data) < $signed(rs2Data));
            f3Bge:   taken = ($signed(rs1Data) >= $signed(rs2Data));
            f3Bltu:  taken = (rs1Data < rs2Data);
            f3Bgeu:  taken = (rs1Data >= rs2Data);
            default: taken = 1'b0; // flagged illegal by the decoder
        endcase
    end

    assign seqPc  = pc + instBytes;
    assign relPc  = pc + dec.imm;
    assign jalrPc = (rs1Data + dec.imm) & ~wordT'(1); // lsb cleared

    always_comb begin
        case (dec.opcode)
            opJal:    nextPc = relPc;
            opJalr:   nextPc = jalrPc;
            opBranch: nextPc = taken ? relPc : seqPc;
            default:  nextPc = seqPc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= resetAddr;
        end else if (pcEn) begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

// File: cpuControl.sv
`timescale 1ns/100ps
`default_nettype none

module cpuControl (
    input  wire       clk,
    input  wire       rst,
    decodeIf.consumer dec,
    input  wire       misaligned,
    output logic      regWrEn,
    output logic      dataWrEn,
    output logic      pcEn,
    output logic      halt
);
    import cpuPkg::*;

    cpuStateE state;
    cpuStateE nextState;
    logic     fault;    // illegal encoding or bad address
    logic     commit;   // this instruction may write
    logic     writesRd;

    assign fault  = dec.illegal || misaligned;
    assign commit = (state == stRun) && !fault;

    always_comb begin
        case (dec.opcode)
            opLui, opAuipc, opJal, opJalr, opLoad, opImm, opReg: writesRd = 1'b1;
            default:                                             writesRd = 1'b0;
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            stRun:    if (fault) nextState = stHalted;
            stHalted: nextState = stHalted; // only reset leaves
            default:  nextState = stHalted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= stRun;
        end else begin
            state <= nextState;
        end
    end

    assign pcEn     = commit;
    assign regWrEn  = commit && writesRd;
    assign dataWrEn = commit && (dec.opcode == opStore);
    assign halt     = (state == stHalted);

endmodule

`default_nettype wire

// File: singleCycleCpu.sv
`timescale 1ns/100ps
`default_nettype none

module singleCycleCpu #(
    parameter cpuPkg::wordT resetAddr = '0
) (
    input  wire               clk,
    input  wire               rst,
    output cpuPkg::wordT      instAddr,   // current pc
    input  wire cpuPkg::wordT instWord,
    output cpuPkg::wordT      dataAddr,
    output cpuPkg::wordT      dataWrData,
    output logic              dataWrEn,
    input  wire cpuPkg::wordT dataRdData,
    output logic              halt
);
    import cpuPkg::*;

    wordT rs1Data;
    wordT rs2Data;
    wordT rdData;     // writeback value
    logic misaligned;
    logic regWrEn;
    logic pcEn;

    decodeIf decBus ();

    instDecoder i_instDecoder (
        .instWord (instWord),
        .dec      (decBus.decoder)
    );

    regFile i_regFile (
        .clk     (clk),
        .rs1     (decBus.rs1),
        .rs2     (decBus.rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .rd      (decBus.rd),
        .rdData  (rdData),
        .regWrEn (regWrEn)
    );

    executeUnit i_executeUnit (
        .dec        (decBus.consumer),
        .pc         (instAddr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .dataRdData (dataRdData),
        .rdData     (rdData),
        .dataAddr   (dataAddr),
        .dataWrData (dataWrData),
        .misaligned (misaligned)
    );

    programCounter #(
        .resetAddr (resetAddr)
    ) i_programCounter (
        .clk     (clk),
        .rst     (rst),
        .dec     (decBus.consumer),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .pcEn    (pcEn),
        .pc      (instAddr)
    );

    cpuControl i_cpuControl (
        .clk        (clk),
        .rst        (rst),
        .dec        (decBus.consumer),
        .misaligned (misaligned),
        .regWrEn    (regWrEn),
        .dataWrEn   (dataWrEn),
        .pcEn       (pcEn),
        .halt       (halt)
    );

endmodule

`default_nettype wire

// File: tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic wordT encR(funct7T f7, regAddrT rs2, regAddrT rs1, funct3T f3, regAddrT rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic wordT encI(logic [11:0] imm, regAddrT rs1, funct3T f3, regAddrT rd,
                              logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic wordT encS(logic [11:0] imm, regAddrT rs2); // sw rs2, imm(x0)
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic wordT encB(logic [12:0] imm, regAddrT rs2, regAddrT rs1, funct3T f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic wordT encU(logic [19:0] imm, regAddrT rd, logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic wordT encJ(logic [20:0] imm, regAddrT rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

task automatic emitTo(wordT w, wordT next);
    imem[bPc[9:2]]    = w;
    expNext[bPc[9:2]] = next;
    bPc += 32'd4;
endtask

task automatic emit(wordT w);
    emitTo(w, bPc + 32'd4);
endtask

task automatic loadConst(regAddrT rd, wordT v);
    wordT hi;
    hi = (v + 32'h800) & 32'hFFFFF000; // addi adds the sign-extended low part
    emit(encU(hi[31:12], rd, 7'b0110111));
    emit(encI(v[11:0], rd, 3'b000, rd, 7'b0010011));
    refRegs[rd] = v;
endtask

task automatic storeReg(string name, regAddrT rs);
    emit(encS(storeOff[11:0], rs));
    expAddrQ.push_back(storeOff);
    expDataQ.push_back(refRegs[rs]);
    expNameQ.push_back(name);
    storeOff += 32'd4;
endtask

task automatic aluReg(string name, funct3T f3, logic alt, regAddrT rs1, regAddrT rs2);
    emit(encR({1'b0, alt, 5'b0}, rs2, rs1, f3, 5'd4));
    refRegs[4] = refAlu(f3, alt, refRegs[rs1], refRegs[rs2]);
    storeReg(name, 5'd4);
endtask

task automatic aluImm(string name, funct3T f3, wordT immSrc, regAddrT rs1);
    logic [11:0] imm;
    imm = immSrc[11:0];
    emit(encI(imm, rs1, f3, 5'd5, 7'b0010011));
    refRegs[5] = refAlu(f3, (f3 == 3'b101) && imm[10], refRegs[rs1], {{20{imm[11]}}, imm});
    storeReg(name, 5'd5);
endtask

task automatic branchTest(funct3T f3, regAddrT rs1, regAddrT rs2);
    logic taken;
    taken = refBranch(f3, refRegs[rs1], refRegs[rs2]);
    emitTo(encB(13'd8, rs2, rs1, f3), bPc + (taken ? 32'd8 : 32'd4));
    if (taken) begin
        emit(encS(storeOff[11:0], 5'd31)); // must be skipped
    end else begin
        storeReg($sformatf("branch f3=%0d fall-through", f3), 5'd1);
    end
endtask

task automatic buildProgram(logic illegalEnd);
    funct3T brF3 [6];
    wordT   tmp;
    brF3     = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    lcgState = 32'd27226;
    bPc      = resetAddr;
    storeOff = 32'h400;
    storeIdx = 0;
    expAddrQ.delete();
    expDataQ.delete();
    expNameQ.delete();
    foreach (imem[i]) begin
        imem[i]    = '0;
        expNext[i] = '0;
    end
    foreach (refRegs[i]) refRegs[i] = '0;
    loadConst(5'd1, lcg() & 32'h7FFFFFFF); // positive operand
    loadConst(5'd2, lcg());
    loadConst(5'd3, lcg() | 32'h80000000); // negative operand
    loadConst(5'd31, poison);
    aluReg("add", 3'b000, 1'b0, 5'd1, 5'd2);
    aluReg("sub", 3'b000, 1'b1, 5'd1, 5'd2);
    aluReg("sll", 3'b001, 1'b0, 5'd3, 5'd2);
    aluReg("slt", 3'b010, 1'b0, 5'd3, 5'd1);
    aluReg("sltu", 3'b011, 1'b0, 5'd3, 5'd1);
    aluReg("xor", 3'b100, 1'b0, 5'd1, 5'd2);
    aluReg("srl", 3'b101, 1'b0, 5'd3, 5'd2);
    aluReg("sra", 3'b101, 1'b1, 5'd3, 5'd2);
    aluReg("or", 3'b110, 1'b0, 5'd1, 5'd2);
    aluReg("and", 3'b111, 1'b0, 5'd1, 5'd2);
    aluImm("addi", 3'b000, lcg(), 5'd1);
    aluImm("slti", 3'b010, lcg(), 5'd3);
    aluImm("sltiu", 3'b011, lcg(), 5'd1);
    aluImm("xori", 3'b100, lcg(), 5'd2);
    aluImm("ori", 3'b110, lcg(), 5'd3);
    aluImm("andi", 3'b111, lcg(), 5'd2);
    aluImm("slli", 3'b001, lcg() & 32'h1F, 5'd2);
    aluImm("srli", 3'b101, lcg() & 32'h1F, 5'd3);
    aluImm("srai", 3'b101, (lcg() & 32'h1F) | 32'h400, 5'd3);
    tmp = lcg();
    emit(encU(tmp[31:12], 5'd6, 7'b0110111));
    refRegs[6] = {tmp[31:12], 12'b0};
    storeReg("lui", 5'd6);
    refRegs[6] = bPc + {tmp[31:12], 12'b0};
    emit(encU(tmp[31:12], 5'd6, 7'b0010111));
    storeReg("auipc", 5'd6);
    storeReg("load source", 5'd2);
    emit(encI(storeOff[11:0] - 12'd4, 5'd0, 3'b010, 5'd7, 7'b0000011));
    refRegs[7] = refRegs[2];
    storeReg("load back", 5'd7);
    foreach (brF3[i]) begin
        branchTest(brF3[i], 5'd1, 5'd1);
        branchTest(brF3[i], 5'd3, 5'd1);
    end
    refRegs[8] = bPc + 32'd4;
    emitTo(encJ(21'd8, 5'd8), bPc + 32'd8);
    emit(encS(storeOff[11:0], 5'd31));
    storeReg("jal link", 5'd8);
    tmp = bPc + 32'd16; // jalr target, odd sum checks bit 0 clearing
    loadConst(5'd9, tmp);
    refRegs[8] = bPc + 32'd4;
    emitTo(encI(12'd1, 5'd9, 3'b000, 5'd8, 7'b1100111), tmp);
    emit(encS(storeOff[11:0], 5'd31));
    storeReg("jalr link", 5'd8);
    faultAddr = bPc; // rd is x1 in both faulting words
    if (illegalEnd) begin
        emitTo(32'h000000FF, bPc);
    end else begin
        emitTo(encI(12'h402, 5'd0, 3'b010, 5'd1, 7'b0000011), bPc);
    end
    progLen = int'((bPc - resetAddr) / 4);
endtask

`endif

// File: tb_singleCycleCpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_singleCycleCpu;
    import cpuPkg::*;

    localparam wordT resetAddr   = 32'h40;
    localparam int   resetCycles = 16;
    localparam int   clkPeriod   = 20;
    localparam wordT poison      = 32'hDEADBEEF; // only skipped stores carry it

    logic clk;
    logic rst;
    wordT instAddr;
    wordT instWord;
    wordT dataAddr;
    wordT dataWrData;
    logic dataWrEn;
    wordT dataRdData;
    logic halt;

    wordT  imem [256];
    wordT  dmem [512];
    wordT  expNext [256];  // successor of each instruction address
    wordT  refRegs [32];   // reference register contents
    wordT  expAddrQ [$];
    wordT  expDataQ [$];
    string expNameQ [$];
    wordT  lcgState;
    wordT  bPc;            // address of the next emitted instruction
    wordT  storeOff;
    wordT  faultAddr;
    wordT  expPc;
    int    storeIdx;
    int    progLen;
    int    valueErrors;
    int    otherErrors;

    singleCycleCpu #(
        .resetAddr (resetAddr)
    ) i_singleCycleCpu (
        .clk        (clk),
        .rst        (rst),
        .instAddr   (instAddr),
        .instWord   (instWord),
        .dataAddr   (dataAddr),
        .dataWrData (dataWrData),
        .dataWrEn   (dataWrEn),
        .dataRdData (dataRdData),
        .halt       (halt)
    );

    assign instWord   = imem[instAddr[9:2]];
    assign dataRdData = dmem[dataAddr[10:2]];

    `include "tbProgram.svh"

    function automatic wordT lcg();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic reportValue(string name, wordT exp, wordT act);
        $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        valueErrors++;
    endtask

    task automatic reportOther(string msg);
        $display("ERROR %s", msg);
        otherErrors++;
    endtask

    // RV32I reference results
    function automatic wordT refAlu(funct3T f3, logic alt, wordT a, wordT b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic refBranch(funct3T f3, wordT a, wordT b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // data memory write and store checks
    always @(posedge clk) begin
        if (rst && dataWrEn) begin
            dmem[dataAddr[10:2]] = dataWrData;
            assert (dataWrData != poison)
                else reportOther("poison value stored, a taken branch fell through");
            if (storeIdx < expAddrQ.size()) begin
                assert (dataAddr == expAddrQ[storeIdx])
                    else reportValue({expNameQ[storeIdx], " addr"}, expAddrQ[storeIdx], dataAddr);
                assert (dataWrData == expDataQ[storeIdx])
                    else reportValue(expNameQ[storeIdx], expDataQ[storeIdx], dataWrData);
            end else begin
                reportOther("store issued after the last expected store");
            end
            storeIdx++;
        end
    end

    // pc sequence, first edge after reset included
    always @(posedge clk) begin
        if (!rst) begin
            expPc <= resetAddr;
        end else begin
            assert (instAddr == expPc) else reportValue("pc sequence", expPc, instAddr);
            expPc <= expNext[instAddr[9:2]];
        end
    end

    assert property (@(posedge clk) $rose(rst) |-> (!halt && !dataWrEn))
        else reportOther("halt or dataWrEn high at the first edge after reset");
    assert property (@(posedge clk) (rst && instAddr == faultAddr) |-> !dataWrEn)
        else reportOther("memory write issued by the faulting instruction");
    assert property (@(posedge clk)
        (rst && !halt && instAddr == faultAddr) |=> (halt && instAddr == faultAddr))
        else reportOther("halt did not rise after the faulting instruction");
    assert property (@(posedge clk) (rst && halt) |=> (halt && $stable(instAddr) && !dataWrEn))
        else reportOther("DUT left the halted state or wrote memory while halted");

    task automatic runProgram(logic illegalEnd);
        @(negedge clk);
        rst = 1'b0;
        buildProgram(illegalEnd);
        repeat (resetCycles) @(negedge clk);
        rst = 1'b1;
        while (!halt) @(negedge clk);
        imem[faultAddr[9:2]] = encS(storeOff[11:0], 5'd1); // legal store at the halted pc
        repeat (4) @(negedge clk); // halted cycles for the sticky checks
        assert (storeIdx == expAddrQ.size()) else reportOther("fewer stores seen than expected");
        assert (i_singleCycleCpu.i_regFile.regs[1] == refRegs[1])
            else reportValue("fault rd", refRegs[1], i_singleCycleCpu.i_regFile.regs[1]);
    endtask

    initial begin
        rst         = 1'b0;
        valueErrors = 0;
        otherErrors = 0;
        storeIdx    = 0;
        progLen     = 0;
        foreach (imem[i]) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 512; i++) begin
            dmem[i] = wordT'(i) * 32'h9E3779B1;
        end
        runProgram(1'b0); // ends on a misaligned lw
        runProgram(1'b1); // ends on an unknown opcode
        $display("value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // two runs of reset plus program plus settle time
    initial begin
        wait (progLen != 0);
        #(2 * (progLen + resetCycles + 16) * clkPeriod);
        $display("watchdog expired before the DUT halted");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
cpuPkg.sv
decodeIf.sv
instDecoder.sv
executeUnit.sv
regFile.sv
programCounter.sv
cpuControl.sv
singleCycleCpu.sv
tb_singleCycleCpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_singleCycleCpu
BUILD_DIR ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST) tbProgram.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
